//--- verilog/vfxp_pkg.sv
// Unit types, APB register map, control field positions and the element view union
`default_nettype none

package vfxp_pkg;

    localparam int APB_ADDR_W = 6;  // Width of PADDR

    // Register map, byte addresses
    localparam logic [APB_ADDR_W-1:0] REG_VS1_LO = 6'h00;
    localparam logic [APB_ADDR_W-1:0] REG_VS1_HI = 6'h04;
    localparam logic [APB_ADDR_W-1:0] REG_VS2_LO = 6'h08;
    localparam logic [APB_ADDR_W-1:0] REG_VS2_HI = 6'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 6'h10;  // Writing here starts an operation
    localparam logic [APB_ADDR_W-1:0] REG_VD_LO  = 6'h14;  // Read only
    localparam logic [APB_ADDR_W-1:0] REG_VD_HI  = 6'h18;  // Read only
    localparam logic [APB_ADDR_W-1:0] REG_VXSAT  = 6'h1C;  // Write 1 to clear

    // Control word layout
    localparam int CTRL_INSTR_LSB = 0;  // 4 bits
    localparam int CTRL_SEW_LSB   = 4;  // 2 bits
    localparam int CTRL_VXRM_LSB  = 6;  // 2 bits

    typedef logic [63:0] bus64_t;

    // Codes 8 to 15 are not assigned
    typedef enum logic [3:0] {
        VSADDU = 4'd0,
        VSADD  = 4'd1,
        VSSUBU = 4'd2,
        VSSUB  = 4'd3,
        VAADDU = 4'd4,
        VAADD  = 4'd5,
        VASUBU = 4'd6,
        VASUB  = 4'd7
    } instr_type_t;

    // One 64-bit word seen as elements of each width
    typedef union packed {
        logic [7:0][7:0]  b;  // Bytes
        logic [3:0][15:0] h;  // Halfwords
        logic [1:0][31:0] w;  // Words
        logic [63:0]      d;  // Doubleword
    } elem_word_u;

endpackage

`default_nettype wire

//--- verilog/riscv_vec_pkg.sv
// RISC-V vector element width and fixed-point rounding mode types
`default_nettype none

package riscv_vec_pkg;

    // Selected element width
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    // Fixed-point rounding mode as encoded in vxrm
    typedef enum logic [1:0] {
        RNU_V = 2'd0,  // Round to nearest, ties up
        RNE_V = 2'd1,  // Round to nearest, ties to even
        RDN_V = 2'd2,  // Round down, plain truncation
        ROD_V = 2'd3   // Round to odd, jam bit into lsb
    } vxrm_t;

endpackage

`default_nettype wire

//--- verilog/vfxp_op_if.sv
// Operation interface between the APB register block and the arithmetic block
`timescale 1ns/1ps
`default_nettype none

interface vfxp_op_if;

    vfxp_pkg::instr_type_t  instr_type;  // Selected instruction
    riscv_vec_pkg::sew_t    sew;         // Element width
    riscv_vec_pkg::vxrm_t   vxrm;        // Rounding mode for averaging ops
    vfxp_pkg::bus64_t       data_vs1;    // Source operand 1
    vfxp_pkg::bus64_t       data_vs2;    // Source operand 2
    vfxp_pkg::bus64_t       data_vd;     // Result
    logic                   sat_ovf;     // Some element was clamped

    // Register side sends the operation and takes back the result
    modport regs (
        output instr_type, sew, vxrm, data_vs1, data_vs2,
        input  data_vd, sat_ovf
    );

    modport alu (
        input  instr_type, sew, vxrm, data_vs1, data_vs2,
        output data_vd, sat_ovf
    );

endinterface

`default_nettype wire

//--- verilog/vsaaddsub.sv
// Packed-SIMD saturating and averaging add and subtract built from chained byte adders
`timescale 1ns/1ps
`default_nettype none

module vsaaddsub (
    vfxp_op_if.alu op
);

    logic                  is_sat;     // VSADDU, VSADD, VSSUBU, VSSUB
    logic                  is_avg;     // VAADDU, VAADD, VASUBU, VASUB
    logic                  is_sub;
    logic                  is_signed;
    logic [2:0]            span;       // Bytes per element minus one
    logic [7:0]            elem_low;   // Byte is the lowest of its element
    logic [7:0]            elem_top;   // Byte holds the sign of its element
    vfxp_pkg::bus64_t      opa;        // Operand 1, inverted when subtracting
    logic [7:0][8:0]       data_a;
    logic [7:0][8:0]       data_b;
    logic [7:0][8:0]       sum9;       // Byte sums with one extension bit
    logic [7:0]            carry_in;
    logic [7:0]            carry_out;  // Carry out of bit 7 of each byte
    logic [7:0]            ovf_byte;
    logic [7:0]            round_inc;
    logic [64:0]           sum_ext;    // Whole sum word plus the top extension bit
    vfxp_pkg::elem_word_u  sat_w;
    vfxp_pkg::elem_word_u  avg_shift;
    vfxp_pkg::elem_word_u  avg_w;

    // Instruction decode
    assign is_sat = op.instr_type inside {vfxp_pkg::VSADDU, vfxp_pkg::VSADD,
                                          vfxp_pkg::VSSUBU, vfxp_pkg::VSSUB};
    assign is_avg = op.instr_type inside {vfxp_pkg::VAADDU, vfxp_pkg::VAADD,
                                          vfxp_pkg::VASUBU, vfxp_pkg::VASUB};
    assign is_sub = op.instr_type inside {vfxp_pkg::VSSUBU, vfxp_pkg::VSSUB,
                                          vfxp_pkg::VASUBU, vfxp_pkg::VASUB};
    assign is_signed = op.instr_type inside {vfxp_pkg::VSADD, vfxp_pkg::VSSUB,
                                             vfxp_pkg::VAADD, vfxp_pkg::VASUB};

    always_comb begin
        case (op.sew)
            riscv_vec_pkg::SEW_8:  span = 3'd0;
            riscv_vec_pkg::SEW_16: span = 3'd1;
            riscv_vec_pkg::SEW_32: span = 3'd3;
            default:               span = 3'd7;
        endcase
    end

    // Element boundaries inside the 64-bit word
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            elem_low[i] = ((3'(i) & span) == 3'd0);
            elem_top[i] = ((3'(i) & span) == span);
        end
    end

    // vd = vs2 + vs1 or vs2 - vs1, the latter as vs2 + ~vs1 + 1
    assign opa = is_sub ? ~op.data_vs1 : op.data_vs1;

    always_comb begin : byte_adders
        logic chain_c;
        chain_c = 1'b0;
        for (int i = 0; i < 8; i++) begin
            // Signed ops sign extend, unsigned ones zero extend the true operand
            data_a[i] = {(is_signed ? opa[8*i+7] : is_sub), opa[8*i +: 8]};
            data_b[i] = {(is_signed & op.data_vs2[8*i+7]), op.data_vs2[8*i +: 8]};
            carry_in[i] = elem_low[i] ? is_sub : chain_c;  // New element restarts the chain
            sum9[i] = data_a[i] + data_b[i] + {8'd0, carry_in[i]};
            carry_out[i] = data_a[i][8] ^ data_b[i][8] ^ sum9[i][8];
            chain_c = carry_out[i];
        end
    end

    // Bit 8 is the exact sign or carry of the element when this is its top byte
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            if (is_signed) begin
                ovf_byte[i] = is_sat & (sum9[i][8] ^ sum9[i][7]);
            end else begin
                ovf_byte[i] = is_sat & sum9[i][8];
            end
        end
    end

    assign op.sat_ovf = |(ovf_byte & elem_top);

    // Clamp every byte of an overflowed element
    always_comb begin : saturate
        logic [2:0] top_idx;
        logic       neg;
        for (int i = 0; i < 8; i++) begin
            top_idx = 3'(i) | span;
            neg     = sum9[top_idx][8];  // Sign of the exact result
            if (!ovf_byte[top_idx]) begin
                sat_w.b[i] = sum9[i][7:0];
            end else if (!is_signed) begin
                sat_w.b[i] = {8{~is_sub}};  // All ones on add, zero on subtract
            end else if (elem_top[i]) begin
                sat_w.b[i] = {neg, {7{~neg}}};
            end else begin
                sat_w.b[i] = {8{~neg}};
            end
        end
    end

    // Averaging takes bits SEW:1 of the extended sum
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            sum_ext[8*i +: 8] = sum9[i][7:0];
        end
        sum_ext[64] = sum9[7][8];
        for (int i = 0; i < 8; i++) begin
            avg_shift.b[i] = {(elem_top[i] ? sum9[i][8] : sum_ext[8*i+8]), sum9[i][7:1]};
        end
    end

    // Rounding increment from the shifted-out bit and the new lsb
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            case (op.vxrm)
                riscv_vec_pkg::RNU_V: round_inc[i] = sum9[i][0];
                riscv_vec_pkg::RNE_V: round_inc[i] = sum9[i][0] & sum9[i][1];
                riscv_vec_pkg::ROD_V: round_inc[i] = sum9[i][0] & ~sum9[i][1];
                default:              round_inc[i] = 1'b0;  // RDN truncates
            endcase
        end
    end

    // Increment uses the lowest byte of each element
    always_comb begin
        avg_w.d = avg_shift.d;
        case (op.sew)
            riscv_vec_pkg::SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    avg_w.b[i] = avg_shift.b[i] + {7'd0, round_inc[i]};
                end
            end
            riscv_vec_pkg::SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    avg_w.h[i] = avg_shift.h[i] + {15'd0, round_inc[2*i]};
                end
            end
            riscv_vec_pkg::SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    avg_w.w[i] = avg_shift.w[i] + {31'd0, round_inc[4*i]};
                end
            end
            default: begin
                avg_w.d = avg_shift.d + {63'd0, round_inc[0]};
            end
        endcase
    end

    // Unused codes give zero
    always_comb begin
        if (is_sat) begin
            op.data_vd = sat_w.d;
        end else if (is_avg) begin
            op.data_vd = avg_w.d;
        end else begin
            op.data_vd = '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/vfxp_apb_regs.sv
// APB slave holding operands, control fields, the captured result and sticky vxsat
`timescale 1ns/1ps
`default_nettype none

module vfxp_apb_regs (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [vfxp_pkg::APB_ADDR_W-1:0]   paddr_i,
    input  logic [31:0]                       pwdata_i,
    output logic [31:0]                       prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    vfxp_op_if.regs                           op
);

    vfxp_pkg::bus64_t       vs1_q;
    vfxp_pkg::bus64_t       vs2_q;
    vfxp_pkg::instr_type_t  instr_q;
    riscv_vec_pkg::sew_t    sew_q;
    riscv_vec_pkg::vxrm_t   vxrm_q;
    vfxp_pkg::bus64_t       vd_q;       // Result captured after launch
    logic                   vxsat_q;
    logic                   capture_q;  // Result is taken on the next edge

    logic                   access;     // Access phase of any transfer
    logic                   wr_en;
    logic                   rd_en;
    logic                   addr_hit;
    logic                   vd_addr;    // Result registers are read only
    logic [31:0]            rd_data;
    logic                   is_sat;

    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i & ~pslverr_o;
    assign rd_en  = access & ~pwrite_i;

    assign is_sat = instr_q inside {vfxp_pkg::VSADDU, vfxp_pkg::VSADD,
                                    vfxp_pkg::VSSUBU, vfxp_pkg::VSSUB};

    // Address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        vd_addr  = 1'b0;
        rd_data  = '0;
        case (paddr_i)
            vfxp_pkg::REG_VS1_LO: rd_data = vs1_q[31:0];
            vfxp_pkg::REG_VS1_HI: rd_data = vs1_q[63:32];
            vfxp_pkg::REG_VS2_LO: rd_data = vs2_q[31:0];
            vfxp_pkg::REG_VS2_HI: rd_data = vs2_q[63:32];
            vfxp_pkg::REG_CTRL: begin
                rd_data[vfxp_pkg::CTRL_INSTR_LSB +: 4] = instr_q;
                rd_data[vfxp_pkg::CTRL_SEW_LSB +: 2]   = sew_q;
                rd_data[vfxp_pkg::CTRL_VXRM_LSB +: 2]  = vxrm_q;
            end
            vfxp_pkg::REG_VD_LO: begin
                rd_data = vd_q[31:0];
                vd_addr = 1'b1;
            end
            vfxp_pkg::REG_VD_HI: begin
                rd_data = vd_q[63:32];
                vd_addr = 1'b1;
            end
            vfxp_pkg::REG_VXSAT: rd_data = {31'd0, vxsat_q};
            default:             addr_hit = 1'b0;
        endcase
    end

    assign pready_o  = 1'b1;  // No wait states
    assign pslverr_o = access & (~addr_hit | (pwrite_i & vd_addr));
    assign prdata_o  = rd_en ? rd_data : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vs1_q     <= '0;
            vs2_q     <= '0;
            instr_q   <= vfxp_pkg::VSADDU;
            sew_q     <= riscv_vec_pkg::SEW_8;
            vxrm_q    <= riscv_vec_pkg::RNU_V;
            vd_q      <= '0;
            vxsat_q   <= 1'b0;
            capture_q <= 1'b0;
        end else begin
            capture_q <= 1'b0;
            if (wr_en) begin
                case (paddr_i)
                    vfxp_pkg::REG_VS1_LO: vs1_q[31:0]  <= pwdata_i;
                    vfxp_pkg::REG_VS1_HI: vs1_q[63:32] <= pwdata_i;
                    vfxp_pkg::REG_VS2_LO: vs2_q[31:0]  <= pwdata_i;
                    vfxp_pkg::REG_VS2_HI: vs2_q[63:32] <= pwdata_i;
                    vfxp_pkg::REG_CTRL: begin
                        instr_q <= vfxp_pkg::instr_type_t'(
                                       pwdata_i[vfxp_pkg::CTRL_INSTR_LSB +: 4]);
                        sew_q   <= riscv_vec_pkg::sew_t'(
                                       pwdata_i[vfxp_pkg::CTRL_SEW_LSB +: 2]);
                        vxrm_q  <= riscv_vec_pkg::vxrm_t'(
                                       pwdata_i[vfxp_pkg::CTRL_VXRM_LSB +: 2]);
                        capture_q <= 1'b1;  // Launch
                    end
                    vfxp_pkg::REG_VXSAT: begin
                        if (pwdata_i[0]) begin
                            vxsat_q <= 1'b0;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            // Capture comes last so it overrides a clear in the same cycle
            if (capture_q) begin
                vd_q <= op.data_vd;
                if (is_sat) begin
                    vxsat_q <= vxsat_q | op.sat_ovf;  // Sticky
                end
            end
        end
    end

    assign op.instr_type = instr_q;
    assign op.sew        = sew_q;
    assign op.vxrm       = vxrm_q;
    assign op.data_vs1   = vs1_q;
    assign op.data_vs2   = vs2_q;

endmodule

`default_nettype wire

//--- verilog/vfxp_apb_top.sv
// Vector fixed-point unit top level with APB register block and arithmetic block
`timescale 1ns/1ps
`default_nettype none

module vfxp_apb_top (
    input  logic                              clk_i,
    input  logic                              rst_i,
    // APB slave port
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [vfxp_pkg::APB_ADDR_W-1:0]   paddr_i,
    input  logic [31:0]                       pwdata_i,
    output logic [31:0]                       prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o
);

    // Operation handed from the registers to the arithmetic block
    vfxp_op_if op_if ();

    vfxp_apb_regs u_regs (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .op        (op_if.regs)
    );

    // Purely combinational, result is ready the cycle after launch
    vsaaddsub u_alu (
        .op (op_if.alu)
    );

endmodule

`default_nettype wire

//--- tests/tb_vfxp_model.svh
// Reference model of the fixed-point instructions, element access helpers and the operand LCG
`ifndef TB_VFXP_MODEL_SVH
`define TB_VFXP_MODEL_SVH

    logic [31:0] lcg_state = 32'd72537;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic vfxp_pkg::bus64_t rand64();
        return {lcg_next(), lcg_next()};
    endfunction

    // Element idx of a word, zero extended
    function automatic logic [63:0] get_elem(input vfxp_pkg::elem_word_u u,
                                             input riscv_vec_pkg::sew_t sew,
                                             input logic [2:0] idx);
        case (sew)
            riscv_vec_pkg::SEW_8:  return {56'd0, u.b[idx]};
            riscv_vec_pkg::SEW_16: return {48'd0, u.h[idx[1:0]]};
            riscv_vec_pkg::SEW_32: return {32'd0, u.w[idx[0]]};
            default:               return u.d;
        endcase
    endfunction

    function automatic vfxp_pkg::elem_word_u set_elem(input vfxp_pkg::elem_word_u u,
                                                      input riscv_vec_pkg::sew_t sew,
                                                      input logic [2:0] idx,
                                                      input logic [63:0] v);
        case (sew)
            riscv_vec_pkg::SEW_8:  u.b[idx] = v[7:0];
            riscv_vec_pkg::SEW_16: u.h[idx[1:0]] = v[15:0];
            riscv_vec_pkg::SEW_32: u.w[idx[0]] = v[31:0];
            default:               u.d = v;
        endcase
        return u;
    endfunction

    // Same value in every element
    function automatic vfxp_pkg::bus64_t fill_elems(input riscv_vec_pkg::sew_t sew,
                                                    input logic [63:0] v);
        vfxp_pkg::elem_word_u u;
        u.d = '0;
        for (int i = 0; i < 8; i++) begin
            u = set_elem(u, sew, 3'(i), v);
        end
        return u.d;
    endfunction

    function automatic logic signed [65:0] extend_elem(input logic [63:0] x, input int w,
                                                       input logic sgn);
        logic signed [65:0] r;
        r = $signed({2'b00, x});
        if (sgn && x[6'(w - 1)]) begin
            r = r - (66'sd1 <<< w);  // Two's complement value of the element
        end
        return r;
    endfunction

    // vd = vs2 op vs1 per element; code bit 0 signed, bit 1 subtract, bit 2 averaging
    function automatic vfxp_pkg::bus64_t model_vd(input logic [3:0] instr,
                                                  input riscv_vec_pkg::sew_t sew,
                                                  input riscv_vec_pkg::vxrm_t vxrm,
                                                  input vfxp_pkg::bus64_t vs1,
                                                  input vfxp_pkg::bus64_t vs2,
                                                  output logic clamped);
        vfxp_pkg::elem_word_u u1;
        vfxp_pkg::elem_word_u u2;
        vfxp_pkg::elem_word_u res;
        int w;
        logic sgn;
        logic inc;
        logic signed [65:0] exact;
        logic signed [65:0] hi;
        logic signed [65:0] lo;
        logic signed [65:0] sh;
        logic signed [65:0] val;
        u1.d = vs1;
        u2.d = vs2;
        res.d = '0;
        clamped = 1'b0;
        if (instr[3]) begin
            return '0;  // Unassigned codes
        end
        w = 8 << int'(sew);
        sgn = instr[0];
        hi = sgn ? (66'sd1 <<< (w - 1)) - 66'sd1 : (66'sd1 <<< w) - 66'sd1;
        lo = sgn ? -(66'sd1 <<< (w - 1)) : 66'sd0;
        for (int i = 0; i < 64 / w; i++) begin
            exact = extend_elem(get_elem(u2, sew, 3'(i)), w, sgn);
            if (instr[1]) begin
                exact = exact - extend_elem(get_elem(u1, sew, 3'(i)), w, sgn);
            end else begin
                exact = exact + extend_elem(get_elem(u1, sew, 3'(i)), w, sgn);
            end
            if (!instr[2]) begin
                val = exact;
                if (exact > hi) begin
                    val = hi;
                    clamped = 1'b1;
                end else if (exact < lo) begin
                    val = lo;
                    clamped = 1'b1;
                end
            end else begin
                sh = exact >>> 1;
                case (vxrm)
                    riscv_vec_pkg::RNU_V: inc = exact[0];
                    riscv_vec_pkg::RNE_V: inc = exact[0] & sh[0];
                    riscv_vec_pkg::ROD_V: inc = exact[0] & ~sh[0];
                    default:              inc = 1'b0;
                endcase
                val = sh + {65'd0, inc};
            end
            res = set_elem(res, sew, 3'(i), val[63:0]);  // Truncates to SEW bits
        end
        return res.d;
    endfunction

`endif

//--- tests/tb_vfxp.sv
// Testbench for the vector fixed-point unit with APB driver, compare tasks and directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_vfxp;

    logic                            clk_i = 1'b0;
    logic                            rst_i;
    logic                            psel_i;
    logic                            penable_i;
    logic                            pwrite_i;
    logic [vfxp_pkg::APB_ADDR_W-1:0] paddr_i;
    logic [31:0]                     pwdata_i;
    logic [31:0]                     prdata_o;
    logic                            pready_o;
    logic                            pslverr_o;
    logic [31:0]                     rdata;      // PRDATA of the last transfer
    logic                            err;        // PSLVERR of the last transfer
    logic                            exp_vxsat;
    vfxp_pkg::bus64_t                last_vd;

    `include "tb_vfxp_model.svh"

    vfxp_apb_top dut (.*);

    always #10 clk_i = ~clk_i;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_vd(input vfxp_pkg::bus64_t got, input vfxp_pkg::bus64_t exp,
                            input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0d ns: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0d ns: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    // Setup cycle, then access cycle until PREADY
    task automatic apb_transfer(input logic wr, input logic [5:0] addr, input logic [31:0] wdata);
        int waits;
        @(posedge clk_i);
        #1;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk_i);
        #1;
        penable_i = 1'b1;
        waits = 0;
        @(negedge clk_i);  // Mid-cycle, outputs have settled
        while (!pready_o) begin
            @(negedge clk_i);
            waits++;
            if (waits > 16) begin
                abort_run("APB transfer saw no PREADY within 16 cycles");
            end
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input logic [5:0] addr, input logic [31:0] data, input logic exp_err);
        apb_transfer(1'b1, addr, data);
        check_flag(err, exp_err, $sformatf("PSLVERR on write to 0x%02h", addr));
    endtask

    task automatic apb_read(input logic [5:0] addr, input logic exp_err);
        apb_transfer(1'b0, addr, 32'd0);
        check_flag(err, exp_err, $sformatf("PSLVERR on read of 0x%02h", addr));
    endtask

    task automatic clear_vxsat();
        apb_write(vfxp_pkg::REG_VXSAT, 32'd1, 1'b0);
        exp_vxsat = 1'b0;
    endtask

    // Load operands, launch, read back vd and vxsat
    task automatic run_op(input logic [3:0] instr, input riscv_vec_pkg::sew_t sew,
                          input riscv_vec_pkg::vxrm_t rm, input vfxp_pkg::bus64_t vs1,
                          input vfxp_pkg::bus64_t vs2);
        vfxp_pkg::bus64_t got;
        logic clamp;
        last_vd = model_vd(instr, sew, rm, vs1, vs2, clamp);
        exp_vxsat = exp_vxsat | clamp;
        apb_write(vfxp_pkg::REG_VS1_LO, vs1[31:0], 1'b0);
        apb_write(vfxp_pkg::REG_VS1_HI, vs1[63:32], 1'b0);
        apb_write(vfxp_pkg::REG_VS2_LO, vs2[31:0], 1'b0);
        apb_write(vfxp_pkg::REG_VS2_HI, vs2[63:32], 1'b0);
        apb_write(vfxp_pkg::REG_CTRL, {24'd0, rm, sew, instr}, 1'b0);
        apb_read(vfxp_pkg::REG_VD_LO, 1'b0);
        got[31:0] = rdata;
        apb_read(vfxp_pkg::REG_VD_HI, 1'b0);
        got[63:32] = rdata;
        check_vd(got, last_vd, $sformatf("vd of instr %0d sew %0d vxrm %0d", instr, sew, rm));
        apb_read(vfxp_pkg::REG_VXSAT, 1'b0);
        check_flag(rdata[0], exp_vxsat, "vxsat");
    endtask

    task automatic reset_values();
        for (int a = 0; a < 32; a += 4) begin
            apb_read(6'(a), 1'b0);
            check_vd({32'd0, rdata}, '0, $sformatf("reset value at 0x%02h", a));
        end
    endtask

    task automatic saturating_ops();
        vfxp_pkg::bus64_t mn;
        riscv_vec_pkg::sew_t sw;
        for (int op = 0; op < 4; op++) begin
            for (int s = 0; s < 4; s++) begin
                sw = riscv_vec_pkg::sew_t'(s[1:0]);
                mn = fill_elems(sw, 64'd1 << ((8 << s) - 1));  // Signed minimum per element
                run_op(4'(op), sw, riscv_vec_pkg::RNU_V, mn, mn);
                run_op(4'(op), sw, riscv_vec_pkg::RNU_V, ~mn, ~mn);
                run_op(4'(op), sw, riscv_vec_pkg::RNU_V, ~mn, mn);
                run_op(4'(op), sw, riscv_vec_pkg::RNU_V, '1, '1);
                repeat (3) run_op(4'(op), sw, riscv_vec_pkg::RNU_V, rand64(), rand64());
            end
        end
    endtask

    // vxsat starts cleared and must stay 0
    task automatic averaging_ops();
        vfxp_pkg::bus64_t mn;
        riscv_vec_pkg::sew_t sw;
        riscv_vec_pkg::vxrm_t rm;
        clear_vxsat();
        for (int op = 4; op < 8; op++) begin
            for (int s = 0; s < 4; s++) begin
                sw = riscv_vec_pkg::sew_t'(s[1:0]);
                mn = fill_elems(sw, 64'd1 << ((8 << s) - 1));
                for (int r = 0; r < 4; r++) begin
                    rm = riscv_vec_pkg::vxrm_t'(r[1:0]);
                    run_op(4'(op), sw, rm, rand64(), rand64());
                    run_op(4'(op), sw, rm, mn, ~mn);
                    run_op(4'(op), sw, rm, '1, '1);
                end
            end
        end
    endtask

    task automatic sticky_vxsat();
        clear_vxsat();
        run_op(vfxp_pkg::VSADDU, riscv_vec_pkg::SEW_8, riscv_vec_pkg::RNU_V, 64'h01, 64'hFF);
        check_flag(rdata[0], 1'b1, "vxsat after clamp");
        run_op(vfxp_pkg::VSADDU, riscv_vec_pkg::SEW_8, riscv_vec_pkg::RNU_V, 64'h01, 64'h01);
        check_flag(rdata[0], 1'b1, "vxsat after non-clamping op");
        clear_vxsat();
        apb_read(vfxp_pkg::REG_VXSAT, 1'b0);
        check_flag(rdata[0], 1'b0, "vxsat after clear");
    endtask

    task automatic error_responses();
        vfxp_pkg::bus64_t got;
        apb_read(6'h20, 1'b1);
        apb_write(6'h3C, 32'h1234_5678, 1'b1);
        run_op(vfxp_pkg::VSSUB, riscv_vec_pkg::SEW_16, riscv_vec_pkg::RNU_V, rand64(), rand64());
        apb_write(vfxp_pkg::REG_VD_LO, 32'hDEAD_BEEF, 1'b1);
        apb_write(vfxp_pkg::REG_VD_HI, 32'hCAFE_F00D, 1'b1);
        apb_read(vfxp_pkg::REG_VD_LO, 1'b0);
        got[31:0] = rdata;
        apb_read(vfxp_pkg::REG_VD_HI, 1'b0);
        got[63:32] = rdata;
        check_vd(got, last_vd, "vd after rejected writes");
    endtask

    task automatic unused_codes();
        clear_vxsat();
        run_op(4'd9, riscv_vec_pkg::SEW_8, riscv_vec_pkg::RNU_V, '1, '1);
        run_op(vfxp_pkg::VSADD, riscv_vec_pkg::SEW_32, riscv_vec_pkg::RNU_V,
               64'h7FFF_FFFF_0000_0001, 64'h7FFF_FFFF_0000_0001);
        run_op(4'd15, riscv_vec_pkg::SEW_64, riscv_vec_pkg::ROD_V, rand64(), rand64());
        check_flag(rdata[0], 1'b1, "vxsat after unused code");
    endtask

    initial begin
        rst_i     = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        exp_vxsat = 1'b0;
        last_vd   = '0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        reset_values();
        saturating_ops();
        averaging_ops();
        sticky_vxsat();
        error_responses();
        unused_codes();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tests
verilog/vfxp_pkg.sv
verilog/riscv_vec_pkg.sv
verilog/vfxp_op_if.sv
verilog/vsaaddsub.sv
verilog/vfxp_apb_regs.sv
verilog/vfxp_apb_top.sv
tests/tb_vfxp.sv

//--- run_verilator.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_vfxp -f verilog.f -o tb_vfxp
./obj_dir/tb_vfxp
